// File: compile.f
verilog/dma_pkg.sv
verilog/dma_sync_fifo.sv
verilog/write_dest_fsm.sv
verilog/dma_write_top.sv
verif/dma_write_checker.sv
verif/tb_dma_write.sv

// File: verif/dma_write_cases.txt
# addr(hex) length(beats) mode(0 STAND_BY, 1 HOST_TO_DDR, 2 DDR_TO_HOST, 3 DDR_TO_DDR)
# err_burst(-1 for none) backpressure_percent payload_seed(hex)
00001000 1 1 -1 0 0000000000000100
00002000 16 2 -1 20 1234567800001000
00003000 17 3 -1 30 0000000000002000
00004000 40 1 -1 40 8000000000003000
00005000 8 0 -1 0 0000000000004000
00006000 5 1 -1 25 0000000000005000
00007000 20 1 1 20 00000000a5a56000
0000a000 12 2 -1 10 0000000000007000
00009000 33 3 -1 50 fedcba9800008000
0000b000 3 1 0 0 0000000000009000
0000c000 16 1 -1 60 000000000000a000
0000c100 2 2 -1 35 000000000000b000

// File: verif/tb_dma_write.sv
/* Testbench for the DMA write subsystem. Replays the case file, answers the memory side
   with random back-pressure and scores bursts, payload and status against the burst rule. */
`timescale 1ns/1ns
`default_nettype none

module tb_dma_write
   import dma_pkg::*;
();

   localparam int MAX_CASES = 64;

   logic      clk         = 1'b0;
   logic      reset_n     = 1'b0;
   logic      desc_push   = 1'b0;
   t_addr     desc_addr   = '0;
   t_length   desc_length = '0;
   t_dma_mode desc_mode   = STAND_BY;
   logic      data_push   = 1'b0;
   t_data     data_in     = '0;
   logic      awready     = 1'b0;
   logic      wready      = 1'b0;
   logic      bvalid      = 1'b0;
   t_resp     bresp       = OKAY;
   logic      clear_error = 1'b0;
   logic      desc_full, data_full, awvalid, wvalid, wlast, bready;
   logic      done, busy, stopped_on_error;
   t_addr     awaddr;
   t_axi_len  awlen;
   t_axi_size awsize;
   t_burst    awburst;
   t_data     wdata;
   t_wr_state wr_state;
   t_perf_cnt clk_cnt, beat_cnt;

   t_addr    case_addr [MAX_CASES];
   int       case_len  [MAX_CASES];
   int       case_mode [MAX_CASES];
   int       case_err  [MAX_CASES];
   int       case_pct  [MAX_CASES];
   t_data    case_seed [MAX_CASES];
   int       n_cases     = 0;
   integer   seed        = 32'h2f41_766c;
   int       bp_pct      = 0;
   int       cur_err     = -1;   // Burst index answered with SLVERR.
   int       exp_bursts  = 0;
   int       aw_cnt      = 0;
   int       beats_seen  = 0;
   int       last_cnt    = 0;
   int       rsp_cnt     = 0;
   int       done_cnt    = 0;
   int       burst_idx   = 0;
   int       data_level  = 0;    // Words held in the payload queue.
   longint   cycle_cnt   = 0;
   longint   cycle_limit = 0;
   t_addr    exp_addr_q[$];
   t_axi_len exp_len_q[$];
   t_burst   exp_burst_q[$];
   t_data    exp_data_q[$];
   bit       exp_last_q[$];
   t_resp    rsp_q[$];

   dma_write_top i_dut (.*);

   bind write_dest_fsm dma_write_checker u_checker (
      .clk              (clk),
      .reset_n          (reset_n),
      .awvalid          (awvalid),
      .awready          (awready),
      .awaddr           (awaddr),
      .awlen            (awlen),
      .wvalid           (wvalid),
      .wready           (wready),
      .wlast            (wlast),
      .bvalid           (bvalid),
      .bready           (bready),
      .bresp            (bresp),
      .done             (done),
      .stopped_on_error (stopped_on_error),
      .wr_state         (wr_state)
   );

   always #20 clk = ~clk;

   task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("ERROR at time %0t: %s: got 0x%0h, expected 0x%0h",
                  $time, what, actual, expected);
         $display("Simulation finished: FAIL");
         $fatal(1, "Mismatch.");
      end
   endtask

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
         $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
         $display("Simulation finished: FAIL");
         $fatal(1, "Timeout.");
      end else if (i_dut.u_wr_fsm.u_checker.assert_fails != 0) begin
         $display("A protocol assertion in the write engine failed.");
         $display("Simulation finished: FAIL");
         $fatal(1, "Assertion failure.");
      end
   end

   // Memory-side responder and scoreboard. Handshakes are sampled before the edge updates.
   always @(posedge clk) begin
      if (!reset_n) begin
         rsp_q.delete();
         data_level = 0;
         awready <= 1'b0;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
         bresp   <= OKAY;
      end else begin
         check_equal(bready, 1'b1, "bready");
         check_equal(desc_full, 1'b0, "desc_full with at most one descriptor queued");
         check_equal(data_full, data_level == DATA_DEPTH, "data_full");
         if (data_push && data_level != DATA_DEPTH) data_level++;
         if (wvalid && wready) data_level--;
         if (done) begin
            done_cnt++;
            check_equal(bvalid && bresp == OKAY, 1'b1, "done without an OKAY response");
            check_equal(rsp_cnt + 1, exp_bursts, "done before the final response");
         end
         if (awvalid && awready) begin
            check_equal(exp_addr_q.size() != 0, 1'b1, "address transfer with no burst due");
            check_equal(awaddr, exp_addr_q.pop_front(), "awaddr");
            check_equal(awlen, exp_len_q.pop_front(), "awlen");
            check_equal(awburst, exp_burst_q.pop_front(), "awburst");
            check_equal(awsize, 3, "awsize");
            aw_cnt++;
         end
         if (bvalid && bready) begin
            void'(rsp_q.pop_front());
            rsp_cnt++;
         end
         if (wvalid && wready) begin
            check_equal(exp_data_q.size() != 0, 1'b1, "write beat with no payload due");
            check_equal(wdata, exp_data_q.pop_front(), "wdata");
            check_equal(wlast, exp_last_q.pop_front(), "wlast");
            beats_seen++;
            if (wlast) begin
               rsp_q.push_back((burst_idx == cur_err) ? SLVERR : OKAY);
               burst_idx++;
               last_cnt++;
            end
         end
         awready <= (($random(seed) & 32'h7fff_ffff) % 100) >= bp_pct;
         wready  <= (($random(seed) & 32'h7fff_ffff) % 100) >= bp_pct;
         bvalid  <= (rsp_q.size() != 0);
         bresp   <= (rsp_q.size() != 0) ? rsp_q[0] : OKAY;
      end
   end

   task automatic read_cases();
      int    fd;
      string line;
      t_addr a;
      int    l, m, e, p;
      t_data s;
      fd = $fopen("verif/dma_write_cases.txt", "r");
      if (fd == 0) begin
         $display("Could not open the case file verif/dma_write_cases.txt.");
         $display("Simulation finished: FAIL");
         $fatal(1, "No stimulus.");
      end else begin
         while (!$feof(fd) && n_cases < MAX_CASES) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#" &&
                $sscanf(line, "%h %d %d %d %d %h", a, l, m, e, p, s) == 6) begin
               case_addr[n_cases] = a;
               case_len[n_cases]  = l;
               case_mode[n_cases] = m;
               case_err[n_cases]  = e;
               case_pct[n_cases]  = p;
               case_seed[n_cases] = s;
               cycle_limit += 4 * (40 + 2 * l);
               n_cases++;
            end
         end
         $fclose(fd);
      end
   endtask

   // Burst k starts at addr + k * 128 and carries 16 beats, the last one the remainder.
   task automatic load_expectations(input int idx);
      int nb;
      int beats;
      int k;
      nb = (case_len[idx] + MAX_BURST_BEATS - 1) / MAX_BURST_BEATS;
      exp_bursts = nb;
      for (k = 0; k < nb; k++) begin
         beats = (k == nb - 1) ? case_len[idx] - k * MAX_BURST_BEATS : MAX_BURST_BEATS;
         exp_addr_q.push_back(case_addr[idx] + k * BURST_BYTES);
         exp_len_q.push_back(t_axi_len'(beats - 1));
         exp_burst_q.push_back((case_mode[idx] == HOST_TO_DDR || case_mode[idx] == DDR_TO_DDR) ?
                               BURST_INCR : BURST_WRAP);
      end
      for (k = 0; k < case_len[idx]; k++) begin
         exp_data_q.push_back(case_seed[idx] + k);
         exp_last_q.push_back((k % MAX_BURST_BEATS == MAX_BURST_BEATS - 1) ||
                              (k == case_len[idx] - 1));
      end
   endtask

   task automatic push_descriptor(input int idx);
      @(posedge clk);
      while (desc_full) @(posedge clk);
      desc_push   <= 1'b1;
      desc_addr   <= case_addr[idx];
      desc_length <= t_length'(case_len[idx]);
      desc_mode   <= t_dma_mode'(case_mode[idx][1:0]);
      @(posedge clk);
      desc_push   <= 1'b0;
   endtask

   // One push every other cycle, so data_full is always current when it is sampled.
   task automatic push_payload(input int idx);
      int i;
      i = 0;
      while (i < case_len[idx]) begin
         @(posedge clk);
         if (!data_full) begin
            data_push <= 1'b1;
            data_in   <= case_seed[idx] + i;
            i++;
         end
         @(posedge clk);
         data_push <= 1'b0;
      end
   endtask

   task automatic run_case(input int idx);
      bit standby;
      bit expect_err;
      standby    = (case_mode[idx] == STAND_BY);
      expect_err = !standby && case_err[idx] >= 0 &&
                   case_err[idx] < (case_len[idx] + MAX_BURST_BEATS - 1) / MAX_BURST_BEATS;
      aw_cnt     = 0;
      beats_seen = 0;
      last_cnt   = 0;
      rsp_cnt    = 0;
      done_cnt   = 0;
      burst_idx  = 0;
      exp_bursts = 0;
      bp_pct  <= case_pct[idx];
      cur_err <= case_err[idx];
      if (!standby) load_expectations(idx);
      push_descriptor(idx);
      if (standby) begin
         repeat (6) @(posedge clk);
         check_equal(aw_cnt, 0, "address transfers for a STAND_BY descriptor");
         check_equal(done_cnt, 0, "done pulses for a STAND_BY descriptor");
      end else begin
         push_payload(idx);
         while (!done && !stopped_on_error) @(posedge clk);
         @(posedge clk);
         check_equal(beats_seen, case_len[idx], "beats written");
         check_equal(exp_data_q.size(), 0, "payload words left unwritten");
         check_equal(aw_cnt, exp_bursts, "address transfers");
         check_equal(last_cnt, exp_bursts, "wlast beats");
         check_equal(beat_cnt, case_len[idx], "beat_cnt status");
         check_equal(clk_cnt >= case_len[idx], 1'b1, "clk_cnt against streamed beats");
         if (expect_err) begin
            check_equal(stopped_on_error, 1'b1, "stopped_on_error after SLVERR");
            check_equal(wr_state, ERROR, "wr_state after SLVERR");
            check_equal(done_cnt, 0, "done pulses on an error descriptor");
            clear_error <= 1'b1;
            @(posedge clk);
            clear_error <= 1'b0;
            @(posedge clk);
            check_equal(stopped_on_error, 1'b0, "stopped_on_error after clear_error");
         end else begin
            check_equal(done_cnt, 1, "done pulses");
         end
      end
      check_equal(busy, 1'b0, "busy in idle");
      check_equal(wr_state, IDLE, "wr_state after the descriptor");
   endtask

   initial begin
      read_cases();
      repeat (10) @(posedge clk);
      reset_n <= 1'b1;
      repeat (2) @(posedge clk);
      check_equal({awvalid, wvalid, done, busy, stopped_on_error}, 0, "outputs after reset");
      check_equal(wr_state, IDLE, "wr_state after reset");
      check_equal({clk_cnt, beat_cnt}, 0, "counters after reset");
      for (int idx = 0; idx < n_cases; idx++) begin
         run_case(idx);
      end
      if (n_cases > 0 && i_dut.u_wr_fsm.u_checker.assert_fails == 0) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         $display("No cases were read or assertions failed: %0d cases, %0d failures.",
                  n_cases, i_dut.u_wr_fsm.u_checker.assert_fails);
         $display("Simulation finished: FAIL");
         $fatal(1, "Run failed.");
      end
   end

endmodule

`default_nettype wire

// File: verif/dma_write_checker.sv
/* Protocol assertions for the write engine, bound into write_dest_fsm by the testbench. */
`timescale 1ns/1ns
`default_nettype none

module dma_write_checker
   import dma_pkg::*;
(
   input logic      clk,
   input logic      reset_n,
   input logic      awvalid,
   input logic      awready,
   input t_addr     awaddr,
   input t_axi_len  awlen,
   input logic      wvalid,
   input logic      wready,
   input logic      wlast,
   input logic      bvalid,
   input logic      bready,
   input t_resp     bresp,
   input logic      done,
   input logic      stopped_on_error,
   input t_wr_state wr_state
);

   int unsigned assert_fails = 0;   // Count of failed assertions.
   t_axi_len    beat_idx;           // Beats already taken in the current burst.
   logic        err_seen;           // A bad response hit the current descriptor.

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         beat_idx <= '0;
      end else if (wr_state == IDLE) begin
         beat_idx <= '0;
      end else if (wvalid && wready) begin
         beat_idx <= wlast ? '0 : beat_idx + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         err_seen <= 1'b0;
      end else if (wr_state == IDLE) begin
         err_seen <= 1'b0;
      end else if (bvalid && bready && (bresp != OKAY)) begin
         err_seen <= 1'b1;
      end
   end

   a_aw_hold: assert property (@(posedge clk) disable iff (!reset_n)
      awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen))
   else begin
      assert_fails++;
      $error("awvalid dropped or the address fields moved before awready.");
   end

   a_wlast_beat: assert property (@(posedge clk) disable iff (!reset_n)
      (wvalid || wlast) |-> wvalid && (wlast == (beat_idx == awlen)))
   else begin
      assert_fails++;
      $error("wlast is high without wvalid or off the final beat of the burst.");
   end

   a_done_error: assert property (@(posedge clk) disable iff (!reset_n)
      done |-> !stopped_on_error && !err_seen)
   else begin
      assert_fails++;
      $error("done is high together with an error or after a bad response.");
   end

   a_state_onehot: assert property (@(posedge clk) disable iff (!reset_n) $onehot(wr_state))
   else begin
      assert_fails++;
      $error("The engine state is not one-hot.");
   end

endmodule

`default_nettype wire

// File: verilog/dma_write_top.sv
/* Destination-write subsystem: descriptor queue, payload queue and the burst
   write engine behind one set of memory-side ports. */
`timescale 1ns/1ns
`default_nettype none

module dma_write_top
   import dma_pkg::*;
(
   input  logic      clk,
   input  logic      reset_n,
   input  logic      desc_push,
   input  t_addr     desc_addr,
   input  t_length   desc_length,
   input  t_dma_mode desc_mode,
   output logic      desc_full,
   input  logic      data_push,
   input  t_data     data_in,
   output logic      data_full,
   output logic      awvalid,
   input  logic      awready,
   output t_addr     awaddr,
   output t_axi_len  awlen,
   output t_axi_size awsize,
   output t_burst    awburst,
   output logic      wvalid,
   input  logic      wready,
   output t_data     wdata,
   output logic      wlast,
   input  logic      bvalid,
   input  t_resp     bresp,
   output logic      bready,
   input  logic      clear_error,
   output logic      done,
   output logic      busy,
   output logic      stopped_on_error,
   output t_wr_state wr_state,
   output t_perf_cnt clk_cnt,
   output t_perf_cnt beat_cnt
);

   logic [DESC_W-1:0] desc_word;
   logic [DESC_W-1:0] desc_head;
   logic              desc_not_empty;
   logic              desc_pop;
   t_data             data_head;
   logic              data_not_empty;
   logic              data_pop;

   assign desc_word = {desc_addr, desc_length, desc_mode};   // Address in the top bits.

   dma_sync_fifo #(
      .WIDTH (DESC_W),
      .DEPTH (DESC_DEPTH)
   ) u_desc_fifo (
      .clk       (clk),
      .reset_n   (reset_n),
      .push      (desc_push),
      .push_data (desc_word),
      .pop       (desc_pop),
      .head      (desc_head),
      .not_empty (desc_not_empty),
      .full      (desc_full)
   );

   dma_sync_fifo #(
      .WIDTH (DATA_W),
      .DEPTH (DATA_DEPTH)
   ) u_data_fifo (
      .clk       (clk),
      .reset_n   (reset_n),
      .push      (data_push),
      .push_data (data_in),
      .pop       (data_pop),
      .head      (data_head),
      .not_empty (data_not_empty),
      .full      (data_full)
   );

   write_dest_fsm u_wr_fsm (
      .clk              (clk),
      .reset_n          (reset_n),
      .desc_not_empty   (desc_not_empty),
      .desc_head        (desc_head),
      .desc_pop         (desc_pop),
      .data_not_empty   (data_not_empty),
      .data_head        (data_head),
      .data_pop         (data_pop),
      .awvalid          (awvalid),
      .awready          (awready),
      .awaddr           (awaddr),
      .awlen            (awlen),
      .awsize           (awsize),
      .awburst          (awburst),
      .wvalid           (wvalid),
      .wready           (wready),
      .wdata            (wdata),
      .wlast            (wlast),
      .bvalid           (bvalid),
      .bresp            (bresp),
      .bready           (bready),
      .clear_error      (clear_error),
      .done             (done),
      .busy             (busy),
      .stopped_on_error (stopped_on_error),
      .wr_state         (wr_state),
      .clk_cnt          (clk_cnt),
      .beat_cnt         (beat_cnt)
   );

endmodule

`default_nettype wire

// File: verilog/write_dest_fsm.sv
/* Write engine: takes one descriptor at a time, cuts it into bursts of up to
   16 beats and drives the address, data and response channels. */
`timescale 1ns/1ns
`default_nettype none

module write_dest_fsm
   import dma_pkg::*;
(
   input  logic              clk,
   input  logic              reset_n,
   input  logic              desc_not_empty,
   input  logic [DESC_W-1:0] desc_head,
   output logic              desc_pop,
   input  logic              data_not_empty,
   input  t_data             data_head,
   output logic              data_pop,
   output logic              awvalid,
   input  logic              awready,
   output t_addr             awaddr,
   output t_axi_len          awlen,
   output t_axi_size         awsize,
   output t_burst            awburst,
   output logic              wvalid,
   input  logic              wready,
   output t_data             wdata,
   output logic              wlast,
   input  logic              bvalid,
   input  t_resp             bresp,
   output logic              bready,
   input  logic              clear_error,
   output logic              done,
   output logic              busy,
   output logic              stopped_on_error,
   output t_wr_state         wr_state,
   output t_perf_cnt         clk_cnt,
   output t_perf_cnt         beat_cnt
);

   t_addr     desc_addr;
   t_length   desc_length;
   t_dma_mode desc_mode;
   t_length   length_m1;
   t_wr_state state;
   t_wr_state next;
   t_length   rem_beats;      // Beats not yet given to any burst.
   t_length   burst_src;
   t_length   burst_beats;
   logic [$clog2(MAX_BURST_BEATS):0]          beat_left;
   logic [LENGTH_W-$clog2(MAX_BURST_BEATS):0] rsp_owed;
   logic      desc_valid;
   logic      load_burst;
   logic      beat_xfer;
   logic      last_xfer;
   logic      rsp_ok;
   logic      rsp_err;

   assign desc_addr   = desc_head[DESC_W-1 -: ADDR_W];
   assign desc_length = desc_head[2 +: LENGTH_W];
   assign desc_mode   = t_dma_mode'(desc_head[1:0]);
   assign desc_valid  = (desc_mode != STAND_BY) && (desc_length != '0);
   assign length_m1   = desc_length - 1'b1;

   assign desc_pop  = (state == IDLE) && desc_not_empty;
   assign awvalid   = (state == ADDR_SETUP);
   assign awsize    = t_axi_size'($clog2(DATA_W / 8));
   assign wvalid    = (state == STREAM) && data_not_empty;
   assign wdata     = data_head;
   assign wlast     = wvalid && (beat_left == 1);
   assign data_pop  = wvalid && wready;   // Pop only when a beat transfers.
   assign beat_xfer = data_pop;
   assign last_xfer = beat_xfer && wlast;
   assign bready    = 1'b1;

   assign busy             = (state != IDLE) && (state != ERROR);
   assign stopped_on_error = (state == ERROR);
   assign wr_state         = state;

   assign rsp_ok  = bvalid && bready && busy && (bresp == OKAY);
   assign rsp_err = bvalid && bready && busy && (bresp != OKAY);
   assign done    = rsp_ok && (state == WAIT_RSP) && (rsp_owed == 1);

   // Next burst size comes from the descriptor on the first burst.
   assign burst_src   = (state == IDLE) ? desc_length : rem_beats;
   assign burst_beats = (burst_src > MAX_BURST_BEATS) ? t_length'(MAX_BURST_BEATS) : burst_src;
   assign load_burst  = (next == ADDR_SETUP) && (state != ADDR_SETUP);

   always_comb begin
      next = state;
      unique case (state)
         IDLE:       if (desc_pop && desc_valid) next = ADDR_SETUP;
         ADDR_SETUP: if (awready) next = FIFO_EMPTY;
         FIFO_EMPTY: if (data_not_empty) next = STREAM;
         STREAM: begin
            if (last_xfer) next = (rem_beats != '0) ? ADDR_SETUP : WAIT_RSP;
         end
         WAIT_RSP:   if (done) next = IDLE;
         ERROR:      if (clear_error) next = IDLE;
         default:    next = IDLE;
      endcase
      if (rsp_err) next = ERROR;   // Any bad response aborts the descriptor.
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         state <= IDLE;
      end else begin
         state <= next;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         rem_beats <= '0;
         beat_left <= '0;
         rsp_owed  <= '0;
      end else begin
         if (load_burst) begin
            rem_beats <= burst_src - burst_beats;
            beat_left <= burst_beats[$clog2(MAX_BURST_BEATS):0];
         end else if (beat_xfer) begin
            beat_left <= beat_left - 1'b1;
         end
         if (desc_pop) begin
            // One response per burst, so ceil(length / 16).
            rsp_owed <= {1'b0, length_m1[LENGTH_W-1:$clog2(MAX_BURST_BEATS)]} + 1'b1;
         end else if (rsp_ok) begin
            rsp_owed <= rsp_owed - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (load_burst) begin
         awaddr <= (state == IDLE) ? desc_addr : awaddr + BURST_BYTES;
         awlen  <= t_axi_len'(burst_beats - 1'b1);
      end
      if (desc_pop) begin
         awburst <= (desc_mode == DDR_TO_HOST) ? BURST_WRAP : BURST_INCR;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         clk_cnt  <= '0;
         beat_cnt <= '0;
      end else if (desc_pop) begin
         clk_cnt  <= '0;
         beat_cnt <= '0;
      end else begin
         if ((state == FIFO_EMPTY) || (state == STREAM)) begin
            clk_cnt <= clk_cnt + 1'b1;
         end
         if (beat_xfer) begin
            beat_cnt <= beat_cnt + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/dma_sync_fifo.sv
/* Single-clock first-word-fall-through FIFO, used for both the descriptor
   queue and the payload queue. */
`timescale 1ns/1ns
`default_nettype none

module dma_sync_fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 4
) (
   input  logic             clk,
   input  logic             reset_n,
   input  logic             push,
   input  logic [WIDTH-1:0] push_data,
   input  logic             pop,
   output logic [WIDTH-1:0] head,
   output logic             not_empty,
   output logic             full
);

   logic [WIDTH-1:0]           mem [DEPTH];
   logic [$clog2(DEPTH)-1:0]   wr_ptr;
   logic [$clog2(DEPTH)-1:0]   rd_ptr;
   logic [$clog2(DEPTH+1)-1:0] count;
   logic                       do_push;
   logic                       do_pop;

   assign do_push   = push && !full;       // A push into a full queue is dropped.
   assign do_pop    = pop && not_empty;
   assign not_empty = (count != '0);
   assign full      = (count == DEPTH[$clog2(DEPTH+1)-1:0]);
   assign head      = mem[rd_ptr];         // Head word is always visible.

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: verilog/dma_pkg.sv
/* Shared widths, bus codes and state encodings for the DMA write engine.
   Modules pull these in with a wildcard import in their headers. */
`default_nettype none

package dma_pkg;

   localparam int DATA_W          = 64;
   localparam int ADDR_W          = 32;
   localparam int LENGTH_W        = 12;   // Descriptor length counts 64-bit beats.
   localparam int MAX_BURST_BEATS = 16;
   localparam int BURST_BYTES     = 128;  // One full burst of 8-byte beats.
   localparam int PERF_CNTR_W     = 16;
   localparam int DESC_DEPTH      = 4;
   localparam int DATA_DEPTH      = 32;
   localparam int DESC_W          = ADDR_W + LENGTH_W + 2;

   typedef logic [DATA_W-1:0]      t_data;
   typedef logic [ADDR_W-1:0]      t_addr;
   typedef logic [LENGTH_W-1:0]    t_length;
   typedef logic [7:0]             t_axi_len;   // Beats minus one.
   typedef logic [2:0]             t_axi_size;
   typedef logic [1:0]             t_burst;
   typedef logic [1:0]             t_resp;
   typedef logic [PERF_CNTR_W-1:0] t_perf_cnt;

   localparam t_burst BURST_FIXED = 2'd0;
   localparam t_burst BURST_INCR  = 2'd1;
   localparam t_burst BURST_WRAP  = 2'd2;

   localparam t_resp OKAY   = 2'd0;
   localparam t_resp EXOKAY = 2'd1;
   localparam t_resp SLVERR = 2'd2;
   localparam t_resp DECERR = 2'd3;

   typedef enum logic [1:0] {
      STAND_BY    = 2'd0,
      HOST_TO_DDR = 2'd1,
      DDR_TO_HOST = 2'd2,
      DDR_TO_DDR  = 2'd3
   } t_dma_mode;

   // One bit per state so status readers can decode without a table.
   typedef enum logic [5:0] {
      IDLE       = 6'b000001,
      ADDR_SETUP = 6'b000010,
      FIFO_EMPTY = 6'b000100,
      STREAM     = 6'b001000,
      WAIT_RSP   = 6'b010000,
      ERROR      = 6'b100000
   } t_wr_state;

endpackage

`default_nettype wire
